//--- all.f
verilog/pack_pkg.sv
verilog/stage_if.sv
verilog/bm_store.sv
verilog/pack_head.sv
verilog/pack_tail.sv
verilog/pack_ctrl.sv
verilog/pack_top.sv
tb/tb_pack.sv

//--- run.sh
#!/usr/bin/env bash
# build the frame packer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_pack -f all.f -o sim_pack

sim_out=$(./obj_dir/sim_pack)
echo "$sim_out"

if grep -qx "Finished with no errors" <<< "$sim_out"; then
	exit 0
else
	exit 1
fi

//--- tb/tb_pack.sv
// tb_pack: frame packer testbench with reference frame model, compare tasks, directed tests
`timescale 1ns/10ps
`default_nettype none

module tb_pack
	import pack_pkg::*;
();

	// about 650 cycles of tests, limit leaves room for some 30 frames
	localparam int CYCLE_LIMIT = 2000;
	localparam int DONE_WAIT = 60;
	localparam int LATENCY = 42;

	logic                   clk_sys;
	logic                   rst_n;
	logic                   frame_start;
	logic                   bm_wr;
	logic [3:0]             bm_waddr;
	logic [7:0]             bm_wdata;
	logic [EXP_BYTES*8-1:0] exp_data;
	logic [7:0]             frame_data;
	logic                   frame_vld;
	logic                   frame_done;
	logic                   busy;

	// model state
	logic [31:0]            rnd_state;
	logic [7:0]             bm_ref [BM_DEPTH];
	logic [EXP_BYTES*8-1:0] exp_val;
	logic [7:0]             exp_frame [FRAME_BYTES];
	logic [7:0]             next_seq;
	logic [7:0]             rx_bytes [$];
	logic [7:0]             got_frame [$];
	int frame_cnt = 0;
	int cycle_cnt = 0;
	int err_cnt = 0;
	int check_cnt = 0;

	pack_top u_pack_top (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.frame_start (frame_start),
		.bm_wr       (bm_wr),
		.bm_waddr    (bm_waddr),
		.bm_wdata    (bm_wdata),
		.exp_data    (exp_data),
		.frame_data  (frame_data),
		.frame_vld   (frame_vld),
		.frame_done  (frame_done),
		.busy        (busy)
	);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == CYCLE_LIMIT) begin
			$display("timeout: run stopped after %0d cycles", CYCLE_LIMIT);
			$display("Finished with errors");
			$finish;
		end
	end

	// byte link monitor, one frame per frame_done
	always @(posedge clk_sys) begin
		if (!rst_n) begin
			rx_bytes.delete();
		end else begin
			if (frame_vld) begin
				rx_bytes.push_back(frame_data);
			end
			if (frame_done) begin
				got_frame = rx_bytes;
				rx_bytes.delete();
				frame_cnt = frame_cnt + 1;
			end
		end
	end

	// ----------------------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------------------
	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %0t: %s is %02h, expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic check_len(input int got);
		check_cnt++;
		if (got != FRAME_BYTES) begin
			err_cnt++;
			$display("ERR %0t: frame length is %0d, expected %0d", $time, got, FRAME_BYTES);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		check_cnt++;
		if (got != exp) begin
			err_cnt++;
			$display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// ----------------------------------------------------------------------
	// stimulus and reference model
	// ----------------------------------------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic apply_reset;
		@(posedge clk_sys);
		rst_n <= 1'b0;
		repeat (5) @(posedge clk_sys);
		rst_n <= 1'b1;
		next_seq = 8'h01;
		@(negedge clk_sys);
	endtask

	task automatic load_random_data;
		int i;
		for (i = 0; i < BM_DEPTH; i++) begin
			rnd_state = xorshift(rnd_state);
			bm_ref[i] = rnd_state[7:0];
			@(posedge clk_sys);
			bm_wr <= 1'b1;
			bm_waddr <= 4'(i);
			bm_wdata <= rnd_state[7:0];
		end
		for (i = 0; i < EXP_BYTES / 4; i++) begin
			rnd_state = xorshift(rnd_state);
			exp_val = {exp_val[EXP_BYTES*8-33:0], rnd_state};
		end
		@(posedge clk_sys);
		bm_wr <= 1'b0;
		exp_data <= exp_val;
	endtask

	// sync, sequence, bitmap from address 0, expansion msb first, xor of all before
	task automatic build_expected(input logic [7:0] seq);
		int i;
		logic [7:0] csum;
		exp_frame[0] = SYNC_BYTE;
		exp_frame[1] = seq;
		for (i = 0; i < BM_DEPTH; i++) begin
			exp_frame[2 + i] = bm_ref[i];
		end
		for (i = 0; i < EXP_BYTES; i++) begin
			exp_frame[2 + BM_DEPTH + i] = exp_val[EXP_BYTES*8-1-8*i -: 8];
		end
		csum = 8'h00;
		for (i = 0; i < FRAME_BYTES - 1; i++) begin
			csum = csum ^ exp_frame[i];
		end
		exp_frame[FRAME_BYTES-1] = csum;
	endtask

	// lat counts from the edge that samples frame_start; extra_at pulses it again
	task automatic send_frame(input int extra_at, output int lat, output bit seen);
		@(posedge clk_sys);
		frame_start <= 1'b1;
		lat = -1;
		seen = 1'b0;
		while (!seen && lat < DONE_WAIT) begin
			@(posedge clk_sys);
			lat++;
			if (lat == extra_at) begin
				check_flag(busy, 1'b1, "busy at second frame_start");
				frame_start <= 1'b1;
			end else begin
				frame_start <= 1'b0;
			end
			seen = frame_done;
		end
		if (!seen) begin
			err_cnt++;
			$display("no frame_done within %0d cycles after frame_start", DONE_WAIT);
		end
		@(negedge clk_sys);
	endtask

	task automatic run_frame(input int extra_at, output int lat);
		bit seen;
		int i;
		load_random_data();
		build_expected(next_seq);
		send_frame(extra_at, lat, seen);
		if (seen) begin
			check_len(got_frame.size());
			for (i = 0; i < FRAME_BYTES && i < got_frame.size(); i++) begin
				check_byte(got_frame[i], exp_frame[i],
					$sformatf("frame %0d byte %0d", next_seq, i));
			end
		end
		next_seq = next_seq + 8'h01;
	endtask

	task automatic report(input string name, input int errs_before);
		if (err_cnt == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, err_cnt - errs_before);
		end
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------
	task automatic test_reset_state;
		int errs;
		errs = err_cnt;
		check_flag(frame_vld, 1'b0, "frame_vld after reset");
		check_flag(frame_done, 1'b0, "frame_done after reset");
		check_flag(busy, 1'b0, "busy after reset");
		report("reset_state", errs);
	endtask

	task automatic test_single_frame;
		int errs;
		int lat;
		errs = err_cnt;
		apply_reset();
		run_frame(-1, lat);
		if (got_frame.size() > 1) begin
			check_byte(got_frame[1], 8'h01, "first sequence number");
		end
		report("single_frame", errs);
	endtask

	task automatic test_back_to_back;
		int errs;
		int lat;
		int n;
		errs = err_cnt;
		apply_reset();
		for (n = 0; n < 5; n++) begin
			while (busy) @(posedge clk_sys);
			run_frame(-1, lat);
		end
		report("back_to_back", errs);
	endtask

	task automatic test_ignored_start;
		int errs;
		int lat;
		int frames_before;
		errs = err_cnt;
		run_frame(10, lat);
		frames_before = frame_cnt;
		repeat (DONE_WAIT) @(posedge clk_sys);
		@(negedge clk_sys);
		check_count(frame_cnt - frames_before, 0, "frames after ignored start");
		check_flag(busy, 1'b0, "busy after ignored start");
		run_frame(-1, lat);
		report("ignored_start", errs);
	endtask

	task automatic test_latency;
		int errs;
		int lat;
		errs = err_cnt;
		run_frame(-1, lat);
		check_count(lat, LATENCY, "frame_start to frame_done cycles");
		report("latency", errs);
	endtask

	initial begin
		clk_sys = 1'b0;
		rst_n = 1'b0;
		frame_start = 1'b0;
		bm_wr = 1'b0;
		bm_waddr = 4'h0;
		bm_wdata = 8'h00;
		exp_data = '0;
		exp_val = '0;
		rnd_state = 32'h28c2_9264;
		next_seq = 8'h01;
		apply_reset();
		test_reset_state();
		test_single_frame();
		test_back_to_back();
		test_ignored_start();
		test_latency();
		$display("checks: %0d, errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/pack_top.sv
// pack_top: frame packer top level, bitmap store, header and tail stages and the sequencer
`timescale 1ns/10ps
`default_nettype none

module pack_top
	import pack_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   frame_start,
	// host bitmap writes
	input  logic                   bm_wr,
	input  logic [3:0]             bm_waddr,
	input  logic [7:0]             bm_wdata,
	// held stable until the tail stage latches it
	input  logic [EXP_BYTES*8-1:0] exp_data,
	// byte link
	output logic [7:0]             frame_data,
	output logic                   frame_vld,
	output logic                   frame_done,
	output logic                   busy
);

	// ----------------------------------------------------------------------
	// internal links
	// ----------------------------------------------------------------------
	stage_if if_head ();
	stage_if if_tail ();

	logic       bm_req;
	logic [7:0] bm_q;

	// ----------------------------------------------------------------------
	// blocks
	// ----------------------------------------------------------------------
	bm_store u_bm_store (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.bm_wr    (bm_wr),
		.bm_waddr (bm_waddr),
		.bm_wdata (bm_wdata),
		.bm_req   (bm_req),
		.bm_q     (bm_q)
	);

	pack_head u_pack_head (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.st      (if_head)
	);

	pack_tail u_pack_tail (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.st       (if_tail),
		.bm_q     (bm_q),
		.bm_req   (bm_req),
		.exp_data (exp_data)
	);

	pack_ctrl u_pack_ctrl (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.frame_start (frame_start),
		.head        (if_head),
		.tail        (if_tail),
		.frame_data  (frame_data),
		.frame_vld   (frame_vld),
		.frame_done  (frame_done),
		.busy        (busy)
	);

endmodule

`default_nettype wire

//--- verilog/pack_ctrl.sv
// pack_ctrl: frame sequencer, fires the stages in turn, merges bytes and appends the checksum
`timescale 1ns/10ps
`default_nettype none

module pack_ctrl
	import pack_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       frame_start,
	// stage links
	stage_if.seq       head,
	stage_if.seq       tail,
	// byte link
	output logic [7:0] frame_data,
	output logic       frame_vld,
	output logic       frame_done,
	output logic       busy
);

	ctrl_state_t state;
	logic start_ok;

	// frame_start only counts while idle
	assign start_ok = (state == CTRL_IDLE) && frame_start;

	// ----------------------------------------------------------------------
	// main FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= CTRL_IDLE;
		end else begin
			case (state)
				CTRL_IDLE: state <= frame_start ? CTRL_HEAD : CTRL_IDLE;
				CTRL_HEAD: state <= head.done ? CTRL_TAIL : CTRL_HEAD;
				CTRL_TAIL: state <= tail.done ? CTRL_CSUM : CTRL_TAIL;
				CTRL_CSUM: state <= CTRL_DONE;
				CTRL_DONE: state <= CTRL_IDLE;
				default:   state <= CTRL_IDLE;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// stage fire pulses
	// ----------------------------------------------------------------------
	logic fire_head;
	logic fire_tail;

	// registered, so each fire lands one cycle after its trigger
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			fire_head <= 1'b0;
			fire_tail <= 1'b0;
		end else begin
			fire_head <= start_ok;
			fire_tail <= (state == CTRL_HEAD) && head.done;
		end
	end

	assign head.fire = fire_head;
	assign tail.fire = fire_tail;

	// ----------------------------------------------------------------------
	// byte merge
	// ----------------------------------------------------------------------
	logic       stage_vld;
	logic [7:0] stage_byte;

	// stages never overlap, header wins just in case
	assign stage_vld = head.vld || tail.vld;
	assign stage_byte = head.vld ? head.data :
	                    tail.vld ? tail.data : 8'h00;

	// ----------------------------------------------------------------------
	// checksum
	// ----------------------------------------------------------------------
	logic [7:0] csum;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			csum <= 8'h00;
		end else if (start_ok) begin
			csum <= 8'h00;
		end else if (stage_vld) begin
			csum <= csum ^ stage_byte;
		end
	end

	// ----------------------------------------------------------------------
	// outputs
	// ----------------------------------------------------------------------
	assign frame_data = (state == CTRL_CSUM) ? csum : stage_byte;
	assign frame_vld = stage_vld || (state == CTRL_CSUM);
	assign frame_done = (state == CTRL_DONE);
	assign busy = (state != CTRL_IDLE);

endmodule

`default_nettype wire

//--- verilog/pack_tail.sv
// pack_tail: tail stage, streams the bitmap bytes and then the shifted expansion word
`timescale 1ns/10ps
`default_nettype none

module pack_tail
	import pack_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   rst_n,
	stage_if.stage                 st,
	// bitmap store read side
	input  logic [7:0]             bm_q,
	output logic                   bm_req,
	// expansion word from the host
	input  logic [EXP_BYTES*8-1:0] exp_data
);

	tail_state_t state;
	logic finish_bm;
	logic finish_ep;

	// ----------------------------------------------------------------------
	// main FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= TAIL_IDLE;
		end else begin
			case (state)
				TAIL_IDLE: state <= st.fire ? TAIL_PREP : TAIL_IDLE;
				TAIL_PREP: state <= TAIL_RDBM;
				TAIL_RDBM: state <= finish_bm ? TAIL_RDEP : TAIL_RDBM;
				TAIL_RDEP: state <= finish_ep ? TAIL_DONE : TAIL_RDEP;
				TAIL_DONE: state <= TAIL_IDLE;
				default:   state <= TAIL_IDLE;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// phase counters
	// ----------------------------------------------------------------------
	logic [4:0] cnt_bm;
	logic [4:0] cnt_ep;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cnt_bm <= 5'h00;
		end else if (state == TAIL_RDBM) begin
			cnt_bm <= cnt_bm + 5'h01;
		end else begin
			cnt_bm <= 5'h00;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cnt_ep <= 5'h00;
		end else if (state == TAIL_RDEP) begin
			cnt_ep <= cnt_ep + 5'h01;
		end else begin
			cnt_ep <= 5'h00;
		end
	end

	// last cycle of each phase
	assign finish_bm = (cnt_bm == 5'(BM_DEPTH - 1));
	assign finish_ep = (cnt_ep == 5'(EXP_BYTES - 1));

	// ----------------------------------------------------------------------
	// expansion shift register
	// ----------------------------------------------------------------------
	logic [EXP_BYTES*8-1:0] sh_ep;

	// loaded in prep, then shifted left a byte per cycle
	always_ff @(posedge clk_sys) begin
		if (state == TAIL_PREP) begin
			sh_ep <= exp_data;
		end else if (state == TAIL_RDEP) begin
			sh_ep <= {sh_ep[EXP_BYTES*8-9:0], 8'h00};
		end
	end

	// ----------------------------------------------------------------------
	// outputs
	// ----------------------------------------------------------------------
	assign bm_req = (state == TAIL_RDBM);
	assign st.done = (state == TAIL_DONE);
	assign st.vld = (state == TAIL_RDBM) || (state == TAIL_RDEP);

	always_comb begin
		case (state)
			TAIL_RDBM: st.data = bm_q;
			// msb first
			TAIL_RDEP: st.data = sh_ep[EXP_BYTES*8-1 -: 8];
			default:   st.data = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/pack_head.sv
// pack_head: header stage, emits the sync byte and the frame sequence number
`timescale 1ns/10ps
`default_nettype none

module pack_head
	import pack_pkg::*;
(
	input  logic    clk_sys,
	input  logic    rst_n,
	stage_if.stage  st
);

	// ----------------------------------------------------------------------
	// main FSM
	// ----------------------------------------------------------------------
	head_state_t state;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= HEAD_IDLE;
		end else begin
			case (state)
				HEAD_IDLE: state <= st.fire ? HEAD_PREP : HEAD_IDLE;
				HEAD_PREP: state <= HEAD_SYNC;
				HEAD_SYNC: state <= HEAD_SEQ;
				HEAD_SEQ:  state <= HEAD_DONE;
				HEAD_DONE: state <= HEAD_IDLE;
				default:   state <= HEAD_IDLE;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// sequence number
	// ----------------------------------------------------------------------
	logic [7:0] seq_num;

	// bumped in prep, so the first frame carries 1
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			seq_num <= 8'h00;
		end else if (state == HEAD_PREP) begin
			seq_num <= seq_num + 8'h01;
		end
	end

	// ----------------------------------------------------------------------
	// outputs
	// ----------------------------------------------------------------------
	assign st.done = (state == HEAD_DONE);
	assign st.vld = (state == HEAD_SYNC) || (state == HEAD_SEQ);

	always_comb begin
		case (state)
			HEAD_SYNC: st.data = SYNC_BYTE;
			HEAD_SEQ:  st.data = seq_num;
			default:   st.data = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/bm_store.sv
// bm_store: 16-byte bitmap register file, host write port and auto-incrementing read port
`timescale 1ns/10ps
`default_nettype none

module bm_store
	import pack_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	// host write port
	input  logic       bm_wr,
	input  logic [3:0] bm_waddr,
	input  logic [7:0] bm_wdata,
	// streaming read port
	input  logic       bm_req,
	output logic [7:0] bm_q
);

	// ----------------------------------------------------------------------
	// storage
	// ----------------------------------------------------------------------
	logic [7:0] mem [0:BM_DEPTH-1];

	always_ff @(posedge clk_sys) begin
		if (bm_wr) begin
			mem[bm_waddr] <= bm_wdata;
		end
	end

	// ----------------------------------------------------------------------
	// read pointer
	// ----------------------------------------------------------------------
	logic [3:0] rd_ptr;

	// wraps to 0 after the last byte, ready for the next frame
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= 4'h0;
		end else if (bm_req) begin
			rd_ptr <= rd_ptr + 4'h1;
		end
	end

	// current byte, no read latency
	assign bm_q = mem[rd_ptr];

endmodule

`default_nettype wire

//--- verilog/stage_if.sv
// stage interface: fire/done handshake and byte stream between sequencer and one stage
`timescale 1ns/10ps
`default_nettype none

interface stage_if;

	// one-cycle start pulse from the sequencer
	logic fire;
	// one-cycle end pulse from the stage
	logic done;
	// byte stream, valid only while vld is high
	logic [7:0] data;
	logic vld;

	// frame stage side
	modport stage (
		input  fire,
		output done,
		output data,
		output vld
	);

	// sequencer side
	modport seq (
		output fire,
		input  done,
		input  data,
		input  vld
	);

endinterface

`default_nettype wire

//--- verilog/pack_pkg.sv
// frame format constants and the state enums of the three FSMs
`default_nettype none

package pack_pkg;

	// ----------------------------------------------------------------------
	// frame format
	// ----------------------------------------------------------------------
	localparam logic [7:0] SYNC_BYTE = 8'hA5;
	localparam int BM_DEPTH = 16;
	localparam int EXP_BYTES = 16;
	// sync + sequence + bitmap + expansion + checksum
	localparam int FRAME_BYTES = 2 + BM_DEPTH + EXP_BYTES + 1;

	// ----------------------------------------------------------------------
	// state encodings
	// ----------------------------------------------------------------------
	typedef enum logic [2:0] {
		HEAD_IDLE = 3'h0,
		HEAD_PREP = 3'h1,
		HEAD_SYNC = 3'h2,
		HEAD_SEQ  = 3'h3,
		HEAD_DONE = 3'h7
	} head_state_t;

	// tail stage states
	typedef enum logic [2:0] {
		TAIL_IDLE = 3'h0,
		TAIL_PREP = 3'h1,
		TAIL_RDBM = 3'h2,
		TAIL_RDEP = 3'h3,
		TAIL_DONE = 3'h7
	} tail_state_t;

	typedef enum logic [2:0] {
		CTRL_IDLE = 3'h0,
		CTRL_HEAD = 3'h1,
		CTRL_TAIL = 3'h2,
		CTRL_CSUM = 3'h3,
		CTRL_DONE = 3'h7
	} ctrl_state_t;

endpackage

`default_nettype wire
